// ==== Makefile ====
# Verilator build for the ITIM and its testbench.
# Every variable can be overridden on the command line, e.g. make sim BUILD_DIR=out

VERILATOR  ?= verilator
TOP        ?= itim_tb
RTL_TOP    ?= itim
FILELIST   ?= itim.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

# Lint the testbench with the design under it.
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; the status follows the pass line in the output.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== itim.f ====
verilog/itim_pkg.sv
verilog/itim_ram_if.sv
verilog/itim_ram.sv
verilog/itim_ctrl.sv
verilog/itim.sv
sim/itim_checker.sv
sim/itim_tb.sv

// ==== sim/itim_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_checker (
  input logic        clock,
  input logic        reset,
  input logic        fetch_valid,
  input logic        fetch_fence,
  input logic        fetch_ready,
  input logic        mem_valid,
  input logic        mem_ready,
  input logic [31:0] mem_addr
);

  logic fence_busy;  // High from fence acceptance through its ready.

  always_ff @(posedge clock) begin
    if (!reset) begin
      fence_busy <= 1'b0;
    end else if (fetch_valid && fetch_fence) begin
      fence_busy <= 1'b1;
    end else if (fetch_ready) begin
      fence_busy <= 1'b0;
    end
  end

  mem_hold: assert property (@(posedge clock) disable iff (!reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
    else $error("memory request dropped or its address moved before mem_ready");

  ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    fetch_ready && !fetch_valid |=> !fetch_ready)
    else $error("fetch_ready held high without a new request");

  fence_quiet: assert property (@(posedge clock) disable iff (!reset)
    fence_busy |-> !mem_valid)
    else $error("memory request raised during the fence walk");

endmodule

bind itim itim_checker checker0 (
  .clock       (clock),
  .reset       (reset),
  .fetch_valid (fetch_valid),
  .fetch_fence (fetch_fence),
  .fetch_ready (fetch_ready),
  .mem_valid   (mem_valid),
  .mem_ready   (mem_ready),
  .mem_addr    (mem_addr)
);

`default_nettype wire

// ==== sim/itim_golden.hex ====
// Columns: operation (1 fetch, 2 fence), address, expected 64-bit data, memory transfers.
// Memory words are the inverse of their address; the word at the address is the low half.

// Cold fill, then a hit.
1 00000100 fffffefbfffffeff 2
1 00000100 fffffefbfffffeff 0
1 00000208 fffffdf3fffffdf7 2
1 00000208 fffffdf3fffffdf7 0

// Out of window, every time.
1 00010000 fffefffbfffeffff 2
1 00010000 fffefffbfffeffff 2
1 80000040 7fffffbb7fffffbf 2

// Second word crosses the top of the window.
1 0000fffc fffeffffffff0003 2
1 0000fffc fffeffffffff0003 2

// Tag conflict on set 0x10, banks 0 and 1.
1 00000500 fffffafbfffffaff 2
1 00000500 fffffafbfffffaff 2
1 00000100 fffffefbfffffeff 0

// One locked word and one free word.
1 00000504 fffffaf7fffffafb 2
1 00000504 fffffaf7fffffafb 2
1 00000100 fffffefbfffffeff 0

// Last bank pairs with bank 0 of the next set.
1 0000003c ffffffbfffffffc3 2
1 0000003c ffffffbfffffffc3 0
1 000003fc fffffbfffffffc03 2
1 000003fc fffffbfffffffc03 0

// Fence, then everything misses once.
2 00000000 0000000000000000 0
1 00000100 fffffefbfffffeff 2
1 00000100 fffffefbfffffeff 0
1 000003fc fffffbfffffffc03 2
1 0000003c ffffffbfffffffc3 2
1 0000003c ffffffbfffffffc3 0

// ==== sim/itim_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_tb;

  localparam int golden_words = 256;                    // Four words per test.
  localparam int wait_limit = itim_pkg::itim_sets + 20;  // Longest wait for one answer.
  localparam logic [3:0] op_fence = 4'd2;

  logic        clock;
  logic        reset;
  logic        fetch_valid;
  logic        fetch_fence;
  logic [31:0] fetch_addr;
  logic        fetch_ready;
  logic [63:0] fetch_rdata;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_ready;
  logic [31:0] mem_rdata;

  logic [63:0] golden [golden_words];
  int          num_tests;
  int          passed;
  int          error_count;
  int          transfer_total;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  itim dut0 (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Clock and watchdog
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Run stopped at cycle %0d before all tests finished", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Instruction memory
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    int unsigned wait_cycles;
    mem_ready = 1'b0;
    mem_rdata = '0;
    transfer_total = 0;
    wait_cycles = $urandom(25) % 4;             // Seeds the generator and draws the first wait.
    forever begin
      @(posedge clock);
      #2;
      if (mem_ready) begin
        mem_ready = 1'b0;                       // The edge just took the word.
        wait_cycles = $urandom_range(3, 0);
      end
      if (mem_valid) begin
        if (wait_cycles == 0) begin
          mem_ready = 1'b1;
          mem_rdata = ~mem_addr;
          transfer_total++;
        end else begin
          wait_cycles--;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Compare tasks
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check_rdata(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s fetch_rdata expected %016h actual %016h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_entry(input string name, input string what,
                             input itim_pkg::itim_entry_u expected,
                             input itim_pkg::itim_entry_u actual);
    if (actual.fields.data !== expected.fields.data) begin
      $display("FAIL %s %s expected %08h actual %08h", name, what,
               expected.fields.data, actual.fields.data);
      error_count++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int expected,
                             input int actual);
    if (actual != expected) begin
      $display("FAIL %s %s expected %0d actual %0d", name, what, expected, actual);
      error_count++;
    end
  endtask

  // One golden record, from the request to the answer.
  task automatic run_test(input int idx);
    logic [3:0]            op;
    logic [31:0]           addr;
    logic [63:0]           exp_data;
    logic [63:0]           rdata;
    int                    exp_count;
    int                    start_transfers;
    int                    latency;
    int                    errors_before;
    logic                  got_ready;
    string                 name;
    itim_pkg::itim_entry_u exp_word;
    itim_pkg::itim_entry_u act_word;
    op = golden[4 * idx][3:0];
    addr = golden[4 * idx + 1][31:0];
    exp_data = golden[4 * idx + 2];
    exp_count = int'(golden[4 * idx + 3][31:0]);
    name = $sformatf("t%02d %s %08h", idx, (op == op_fence) ? "fence" : "fetch", addr);
    errors_before = error_count;
    start_transfers = transfer_total;
    rdata = '0;
    fetch_valid = 1'b1;
    fetch_fence = (op == op_fence);
    fetch_addr = addr;
    @(posedge clock);
    #2;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    latency = 0;
    got_ready = 1'b0;
    while (!got_ready && latency < wait_limit) begin
      @(negedge clock);
      latency++;
      if (fetch_ready) begin
        got_ready = 1'b1;
        rdata = fetch_rdata;
      end
    end
    if (!got_ready) begin
      $display("%s got no fetch_ready within %0d cycles", name, wait_limit);
      error_count++;
    end else begin
      check_rdata(name, exp_data, rdata);
      for (int half = 0; half < 2; half++) begin
        exp_word = '0;
        act_word = '0;
        exp_word.fields.data = exp_data[32 * half +: 32];
        act_word.fields.data = rdata[32 * half +: 32];
        check_entry(name, (half == 0) ? "low word" : "high word", exp_word, act_word);
      end
      check_count(name, "memory transfers", exp_count, transfer_total - start_transfers);
      if (op == op_fence) begin
        check_count(name, "ready latency", itim_pkg::itim_sets + 1, latency);
      end else if (exp_count == 0) begin
        check_count(name, "ready latency", 1, latency);      // A hit answers next cycle.
      end
    end
    @(posedge clock);
    #2;
    if (error_count == errors_before) begin
      passed++;
    end
    $display("%s: %s after %0d cycles", name,
             (error_count == errors_before) ? "passed" : "failed", latency);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Golden replay
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_fence = 1'b0;
    fetch_addr = '0;
    passed = 0;
    error_count = 0;
    num_tests = 0;
    for (int i = 0; i < golden_words; i++) begin
      golden[i] = '0;
    end
    $readmemh("sim/itim_golden.hex", golden);
    while (4 * num_tests + 3 < golden_words && golden[4 * num_tests][3:0] != 4'd0) begin
      num_tests++;                                // A zero operation ends the list.
    end
    cycle_limit = num_tests * wait_limit + 10;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b1;
    if (num_tests == 0) begin
      $display("The golden file holds no tests");
      error_count++;
    end
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", num_tests, passed,
             num_tests - passed, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/itim.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim (
  input  logic        clock,
  input  logic        reset,

  // Fetch port.
  input  logic        fetch_valid,
  input  logic        fetch_fence,
  input  logic [31:0] fetch_addr,
  output logic        fetch_ready,
  output logic [63:0] fetch_rdata,

  // Instruction memory port.
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  input  logic        mem_ready,
  input  logic [31:0] mem_rdata
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Bank array
  // ~~~~~~~~~~~~~~~~~~~~

  itim_ram_if banks [itim_pkg::itim_banks] ();

  for (genvar i = 0; i < itim_pkg::itim_banks; i++) begin : gen_bank
    itim_ram bank (
      .clock (clock),
      .port  (banks[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Controller
  // ~~~~~~~~~~~~~~~~~~~~

  itim_ctrl ctrl (
    .clock       (clock),
    .reset       (reset),
    .banks       (banks),
    .fetch_valid (fetch_valid),
    .fetch_fence (fetch_fence),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_rdata (fetch_rdata),
    .mem_valid   (mem_valid),
    .mem_addr    (mem_addr),
    .mem_ready   (mem_ready),
    .mem_rdata   (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== verilog/itim_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_ctrl (
  input  logic        clock,
  input  logic        reset,
  itim_ram_if.ctrl    banks [itim_pkg::itim_banks],
  input  logic        fetch_valid,
  input  logic        fetch_fence,
  input  logic [31:0] fetch_addr,
  output logic        fetch_ready,
  output logic [63:0] fetch_rdata,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  input  logic        mem_ready,
  input  logic [31:0] mem_rdata
);

  logic [31:0]                    in_addr1;
  logic [itim_pkg::bank_bits-1:0] in_bank0, in_bank1;
  logic [itim_pkg::set_bits-1:0]  in_set0, in_set1;
  logic [itim_pkg::tag_bits-1:0]  in_tag0, in_tag1;
  logic [itim_pkg::set_bits-1:0]  rd_set [itim_pkg::itim_banks];

  logic                           req_valid;
  logic                           req_fence;
  logic [31:0]                    req_addr0, req_addr1;
  logic [itim_pkg::bank_bits-1:0] req_bank0, req_bank1;
  logic [itim_pkg::set_bits-1:0]  req_set0, req_set1;
  logic [itim_pkg::tag_bits-1:0]  req_tag0, req_tag1;

  itim_pkg::itim_entry_u          bank_rd [itim_pkg::itim_banks];
  itim_pkg::itim_entry_u          ent0, ent1;
  logic                           in_win, locked, tag_match;

  logic [1:0]                     state, state_d;
  logic                           second, second_d;
  logic                           wr0, wr0_d, wr1, wr1_d;
  logic [itim_pkg::set_bits-1:0]  walk_set, walk_d;
  logic [31:0]                    low_word, low_d;

  logic [itim_pkg::itim_banks-1:0] wr_en;
  logic [itim_pkg::set_bits-1:0]   wr_set;
  itim_pkg::itim_entry_u           wr_data;

  function automatic logic in_window(input logic [31:0] addr);
    return (addr - itim_pkg::itim_base_addr) <
           (itim_pkg::itim_top_addr - itim_pkg::itim_base_addr);
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Front stage
  // ~~~~~~~~~~~~~~~~~~~~

  assign in_addr1 = fetch_addr + 32'd4;
  assign in_bank0 = fetch_addr[itim_pkg::set_lsb-1:itim_pkg::bank_lsb];
  assign in_bank1 = in_addr1[itim_pkg::set_lsb-1:itim_pkg::bank_lsb];
  assign in_set0 = fetch_addr[itim_pkg::tag_lsb-1:itim_pkg::set_lsb];
  assign in_set1 = in_addr1[itim_pkg::tag_lsb-1:itim_pkg::set_lsb];
  assign in_tag0 = fetch_addr[31:itim_pkg::tag_lsb];
  assign in_tag1 = in_addr1[31:itim_pkg::tag_lsb];

  // The two words always sit in neighbouring banks.
  always_comb begin
    for (int i = 0; i < itim_pkg::itim_banks; i++) begin
      rd_set[i] = '0;
    end
    rd_set[in_bank0] = in_set0;
    rd_set[in_bank1] = in_set1;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_valid <= 1'b0;
      req_fence <= 1'b0;
    end else begin
      req_valid <= fetch_valid;
      req_fence <= fetch_valid & fetch_fence;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      req_addr0 <= fetch_addr;
      req_addr1 <= in_addr1;
      req_bank0 <= in_bank0;
      req_bank1 <= in_bank1;
      req_set0 <= in_set0;
      req_set1 <= in_set1;
      req_tag0 <= in_tag0;
      req_tag1 <= in_tag1;
    end
  end

  for (genvar g = 0; g < itim_pkg::itim_banks; g++) begin : gen_port
    assign banks[g].raddr = rd_set[g];
    assign banks[g].wen = wr_en[g];
    assign banks[g].waddr = wr_set;
    assign banks[g].wdata = wr_data;
    assign bank_rd[g] = banks[g].rdata;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Back stage
  // ~~~~~~~~~~~~~~~~~~~~

  assign ent0 = bank_rd[req_bank0];
  assign ent1 = bank_rd[req_bank1];
  assign in_win = in_window(req_addr0) && in_window(req_addr1);
  assign locked = ent0.fields.lock && ent1.fields.lock;
  assign tag_match = (ent0.fields.tag == req_tag0) && (ent1.fields.tag == req_tag1);

  assign mem_valid = (state == itim_pkg::st_fill) || (state == itim_pkg::st_bypass);
  assign mem_addr = second ? req_addr1 : req_addr0;

  always_comb begin
    state_d = state;
    second_d = second;
    wr0_d = wr0;
    wr1_d = wr1;
    walk_d = walk_set;
    low_d = low_word;
    fetch_ready = 1'b0;
    fetch_rdata = '0;
    wr_en = '0;
    wr_set = '0;
    wr_data = '0;
    case (state)
      itim_pkg::st_idle: begin
        second_d = 1'b0;
        if (req_valid) begin
          if (req_fence) begin
            state_d = itim_pkg::st_fence;
            walk_d = '0;
          end else if (!in_win) begin
            state_d = itim_pkg::st_bypass;
          end else if (!locked) begin
            state_d = itim_pkg::st_fill;
            wr0_d = !ent0.fields.lock;                // Locked entries are never replaced.
            wr1_d = !ent1.fields.lock;
          end else if (!tag_match) begin
            state_d = itim_pkg::st_bypass;
          end else begin
            fetch_ready = 1'b1;
            fetch_rdata = {ent1.fields.data, ent0.fields.data};
          end
        end
      end
      itim_pkg::st_fill, itim_pkg::st_bypass: begin
        if (mem_ready) begin
          wr_data.fields.lock = 1'b1;
          wr_data.fields.data = mem_rdata;
          if (!second) begin
            second_d = 1'b1;
            low_d = mem_rdata;
            wr_set = req_set0;
            wr_data.fields.tag = req_tag0;
            wr_en[req_bank0] = (state == itim_pkg::st_fill) && wr0;
          end else begin
            state_d = itim_pkg::st_idle;
            fetch_ready = 1'b1;
            fetch_rdata = {mem_rdata, low_word};
            wr_set = req_set1;
            wr_data.fields.tag = req_tag1;
            wr_en[req_bank1] = (state == itim_pkg::st_fill) && wr1;
          end
        end
      end
      default: begin
        // Fence walk clears one set of every bank per cycle.
        wr_en = '1;
        wr_set = walk_set;
        if (walk_set == itim_pkg::last_set) begin
          state_d = itim_pkg::st_idle;
          fetch_ready = 1'b1;
        end else begin
          walk_d = walk_set + 1;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= itim_pkg::st_idle;
      second <= 1'b0;
      wr0 <= 1'b0;
      wr1 <= 1'b0;
      walk_set <= '0;
    end else begin
      state <= state_d;
      second <= second_d;
      wr0 <= wr0_d;
      wr1 <= wr1_d;
      walk_set <= walk_d;
    end
  end

  always_ff @(posedge clock) begin
    low_word <= low_d;                                // First word of a memory pair.
  end

endmodule

`default_nettype wire

// ==== verilog/itim_pkg.sv ====
`default_nettype none

package itim_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Geometry
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int itim_sets = 64;
  localparam int itim_banks = 4;
  localparam int set_bits = 6;
  localparam int bank_bits = 2;
  localparam int tag_bits = 32 - set_bits - bank_bits - 2;
  localparam int entry_bits = 1 + tag_bits + 32;

  localparam int bank_lsb = 2;                      // Byte offset sits below the bank index.
  localparam int set_lsb = bank_lsb + bank_bits;
  localparam int tag_lsb = set_lsb + set_bits;

  localparam logic [set_bits-1:0] last_set = set_bits'(itim_sets - 1);

  // ~~~~~~~~~~~~~~~~~~~~
  // Address window
  // ~~~~~~~~~~~~~~~~~~~~

  localparam logic [31:0] itim_base_addr = 32'h0000_0000;  // Inclusive.
  localparam logic [31:0] itim_top_addr = 32'h0001_0000;   // Exclusive.

  // Back stage states.
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_fill = 2'd1;
  localparam logic [1:0] st_bypass = 2'd2;
  localparam logic [1:0] st_fence = 2'd3;

  // ~~~~~~~~~~~~~~~~~~~~
  // Bank word
  // ~~~~~~~~~~~~~~~~~~~~

  // The bank stores the raw word and the controller reads the fields.
  typedef union packed {
    logic [entry_bits-1:0] raw;
    struct packed {
      logic                lock;                   // Set once the entry holds a fetched word.
      logic [tag_bits-1:0] tag;
      logic [31:0]         data;
    } fields;
  } itim_entry_u;

endpackage

`default_nettype wire

// ==== verilog/itim_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module itim_ram (
  input logic     clock,
  itim_ram_if.ram port
);

  logic [itim_pkg::entry_bits-1:0] mem [itim_pkg::itim_sets] = '{default: '0};  // Starts unlocked.
  logic [itim_pkg::set_bits-1:0]   raddr_q = '0;

  always_ff @(posedge clock) begin
    raddr_q <= port.raddr;
    if (port.wen) begin
      mem[port.waddr] <= port.wdata.raw;
    end
  end

  // A write shows on the read port right after its edge.
  assign port.rdata.raw = mem[raddr_q];

endmodule

`default_nettype wire

// ==== verilog/itim_ram_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface itim_ram_if;

  logic                          wen;
  logic [itim_pkg::set_bits-1:0] waddr;
  logic [itim_pkg::set_bits-1:0] raddr;
  itim_pkg::itim_entry_u         wdata;
  itim_pkg::itim_entry_u         rdata;  // Entry at the raddr of the previous edge.

  modport ctrl (
    output wen,
    output waddr,
    output raddr,
    output wdata,
    input  rdata
  );

  modport ram (
    input  wen,
    input  waddr,
    input  raddr,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire
